// File: cmprs_block_dc.f
+incdir+include
design/cmprs_cfg_pkg.sv
design/cmprs_blk_if.sv
design/cmprs_cfg_regs.sv
design/cmprs_pixel_in.sv
design/cmprs_block_buf.sv
design/cmprs_nodc_out.sv
design/cmprs_block_dc.sv
testbench/cmprs_block_dc_properties.sv
testbench/cmprs_block_dc_tb.sv

// File: Bender.yml
package:
  name: cmprs_block_dc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/cmprs_cfg_pkg.sv
      - design/cmprs_blk_if.sv
      - design/cmprs_cfg_regs.sv
      - design/cmprs_pixel_in.sv
      - design/cmprs_block_buf.sv
      - design/cmprs_nodc_out.sv
      - design/cmprs_block_dc.sv
  - target: simulation
    files:
      - testbench/cmprs_block_dc_properties.sv
      - testbench/cmprs_block_dc_tb.sv

// File: testbench/cmprs_block_dc_tb.sv
// testbench for the block dc stage, random and saturated blocks checked against a queue model
`timescale 1ns/1ps
`default_nettype none

module cmprs_block_dc_tb;
    import cmprs_cfg_pkg::*;

    typedef struct {
        int avr;
        int n000;
        int n255;
        int first;
        int last;
    } exp_blk_t;

    logic              xclk = 1'b0;
    logic              rst_n_i;
    logic              frame_en_i;
    logic              pre_first_i;
    logic              pix_dv_i;
    logic [7:0]        pix_i;
    logic              cfg_we_i;
    logic              cfg_sel_i;
    cmprs_cfg_u        cfg_word_i;
    logic              ds_o;
    logic              dv_o;
    logic signed [9:0] nodc_o;
    logic [7:0]        avr_o;
    logic              first_o;
    logic              last_o;
    logic [6:0]        n000_o;
    logic [6:0]        n255_o;

    exp_blk_t          blk_q[$];    // blocks still to come out, in order
    int                nodc_q[$];   // pixels after dc removal, in order
    int                mode_dc = 1; // mirrors subtract_dc
    int                n_m1 = 0;    // mirrors n_blocks_m1
    int                blk_idx = 0; // block index inside frame

    cmprs_block_dc UUT (.*);

    always #50 xclk = ~xclk; // 100 ns period

    task automatic check_eq(input int got, input int want, input string what);
        assert (got == want) else begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // outputs settle after the rising edge, look at them on the falling one
    always @(negedge xclk) begin
        if (rst_n_i && ds_o) begin
            assert (blk_q.size() > 0) else begin
                $display("ds_o pulsed while no block was pending");
                $display("Errors found");
                $fatal(1);
            end
            check_eq(avr_o, blk_q[0].avr, "avr_o");
            check_eq(n000_o, blk_q[0].n000, "n000_o");
            check_eq(n255_o, blk_q[0].n255, "n255_o");
            check_eq(first_o, blk_q[0].first, "first_o");
            check_eq(last_o, blk_q[0].last, "last_o");
            blk_q.delete(0);
        end
        if (rst_n_i && dv_o) begin
            assert (nodc_q.size() > 0) else begin
                $display("dv_o was high while no pixel was pending");
                $display("Errors found");
                $fatal(1);
            end
            check_eq(nodc_o, nodc_q[0], "nodc_o");
            nodc_q.delete(0);
        end
    end

    always @(negedge xclk) begin
        if (UUT.props_i.fail_cnt != 0) begin // bound strobe checks
            $display("a bound timing assertion on ds_o or dv_o failed");
            $display("Errors found");
            $fatal(1);
        end
    end

    task automatic write_cfg(input logic sel, input cmprs_cfg_u word);
        @(posedge xclk);
        #10;
        cfg_we_i   = 1'b1;
        cfg_sel_i  = sel;
        cfg_word_i = word;
        @(posedge xclk);
        #10;
        cfg_we_i   = 1'b0;
    endtask

    // n blocks back to back, kind 0 random, 1 all 0, 2 all 255, 3 mix of 0 and 255
    task automatic send_blocks(input int n, input int kind0);
        int       pix[64];
        int       sum;
        int       kind;
        int       i;
        int       j;
        exp_blk_t eb;
        @(posedge xclk);
        #10;
        pre_first_i = 1'b1; // first block announced on its own cycle
        for (j = 0; j < n; j++) begin
            kind    = (kind0 + j) % 4;
            sum     = 0;
            eb.n000 = 0;
            eb.n255 = 0;
            for (i = 0; i < 64; i++) begin
                case (kind)
                    0:       pix[i] = $urandom & 8'hff;
                    1:       pix[i] = 0;
                    2:       pix[i] = 255;
                    default: pix[i] = ($urandom & 1) ? 255 : 0;
                endcase
                sum     += pix[i];
                eb.n000 += (pix[i] == 0);
                eb.n255 += (pix[i] == 255);
            end
            eb.avr   = (sum + 32) >> 6;         // rounded mean of 64
            eb.first = (blk_idx == 0);
            eb.last  = (blk_idx == n_m1);
            blk_idx  = eb.last ? 0 : blk_idx + 1; // wraps into next frame
            blk_q.push_back(eb);
            for (i = 0; i < 64; i++)
                nodc_q.push_back(pix[i] - (mode_dc ? eb.avr : 128));
            for (i = 0; i < 64; i++) begin
                @(posedge xclk);
                #10;
                pix_dv_i    = 1'b1;
                pix_i       = pix[i];
                pre_first_i = (i == 63) && (j < n - 1); // next block on last pixel
            end
        end
        @(posedge xclk);
        #10;
        pix_dv_i    = 1'b0;
        pre_first_i = 1'b0;
    endtask

    task automatic wait_drain();
        int cyc;
        cyc = 0;
        while ((blk_q.size() != 0 || nodc_q.size() != 0) && cyc < 300) begin
            @(posedge xclk);
            cyc++;
        end
        if (blk_q.size() != 0 || nodc_q.size() != 0) begin
            $display("timeout: no block came out of the DUT within %0d cycles", cyc);
            $display("Errors found");
            $fatal(1);
        end else begin
            repeat (3) @(posedge xclk);
        end
    endtask

    initial begin
        cmprs_cfg_u w;
        void'($urandom(32'h8e68fc46));
        rst_n_i     = 1'b0;
        frame_en_i  = 1'b0;
        pre_first_i = 1'b0;
        pix_dv_i    = 1'b0;
        pix_i       = '0;
        cfg_we_i    = 1'b0;
        cfg_sel_i   = 1'b0;
        cfg_word_i  = '0;
        repeat (2) @(posedge xclk);
        #10;
        rst_n_i = 1'b1;
        repeat (4) @(posedge xclk);  // idle, no strobes expected
        #10;
        frame_en_i = 1'b1;
        repeat (4) @(posedge xclk);
        send_blocks(4, 0);           // one block per frame, every kind
        wait_drain();
        w = '0;
        w.frame_fmt.n_blocks_m1 = 2;
        write_cfg(1'b0, w);
        n_m1 = 2;
        send_blocks(6, 1);           // two full frames of three
        wait_drain();
        send_blocks(1, 0);           // frame left open
        wait_drain();
        #10;
        frame_en_i = 1'b0;           // restarts the block count
        blk_idx    = 0;
        repeat (2) @(posedge xclk);
        #10;
        frame_en_i = 1'b1;
        send_blocks(3, 3);
        wait_drain();
        w = '0;
        w.mode_fmt.subtract_dc = 1'b0;
        write_cfg(1'b1, w);
        mode_dc = 0;                 // now pixel minus 128
        send_blocks(4, 0);
        wait_drain();
        if (UUT.props_i.fail_cnt == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: testbench/cmprs_block_dc_properties.sv
// strobe timing and quiet reset checks for the block dc stage outputs
`timescale 1ns/1ps
`default_nettype none

module cmprs_block_dc_properties (
    input wire xclk,
    input wire rst_n_i,
    input wire frame_en_i,
    input wire ds_o,
    input wire dv_o,
    input wire first_o,
    input wire last_o
);
    int fail_cnt = 0; // failed assertions so far

    // nothing comes out of reset
    reset_quiet: assert property (@(posedge xclk)
        !rst_n_i |=> !ds_o && !dv_o && !first_o && !last_o)
        else begin $error("strobes active after reset"); fail_cnt++; end

    // 64 data cycles, stream continues only if the next block was announced
    ds_dv_len: assert property (@(posedge xclk) disable iff (!rst_n_i || !frame_en_i)
        ds_o |=> dv_o [*64] ##1 (!dv_o || $past(ds_o)))
        else begin $error("ds_o not followed by 64 dv_o cycles"); fail_cnt++; end

    dv_after_ds: assert property (@(posedge xclk) disable iff (!rst_n_i || !frame_en_i)
        $rose(dv_o) |-> $past(ds_o))
        else begin $error("dv_o rose without ds_o"); fail_cnt++; end

endmodule

bind cmprs_block_dc cmprs_block_dc_properties props_i (
    .xclk       (xclk),
    .rst_n_i    (rst_n_i),
    .frame_en_i (frame_en_i),
    .ds_o       (ds_o),
    .dv_o       (dv_o),
    .first_o    (first_o),
    .last_o     (last_o)
);

`default_nettype wire

// File: design/cmprs_block_dc.sv
// block dc removal stage top, pixel input to block memory to dc-free readout
`timescale 1ns/1ps
`default_nettype none

`include "cmprs_defs.svh"

module cmprs_block_dc (
    input  wire                               xclk,
    input  wire                               rst_n_i,
    input  wire                               frame_en_i,
    input  wire                               pre_first_i,
    input  wire                               pix_dv_i,
    input  wire        [`CMPRS_PIX_W-1:0]     pix_i,
    input  wire                               cfg_we_i,
    input  wire                               cfg_sel_i,
    input  cmprs_cfg_pkg::cmprs_cfg_u         cfg_word_i,
    output logic                              ds_o,
    output logic                              dv_o,
    output logic signed [`CMPRS_NODC_W-1:0]   nodc_o,
    output logic       [`CMPRS_PIX_W-1:0]     avr_o,
    output logic                              first_o,
    output logic                              last_o,
    output logic       [`CMPRS_CNT_W-1:0]     n000_o,
    output logic       [`CMPRS_CNT_W-1:0]     n255_o
);

    logic [`CMPRS_NBLK_W-1:0]  n_blocks_m1; // from frame word
    logic                      subtract_dc; // from mode word

    cmprs_wr_if wr_bus ();                  // pixel input to block memory
    cmprs_rd_if rd_bus ();                  // block memory to readout

    cmprs_cfg_regs cmprs_cfg_regs_i (
        .xclk          (xclk),
        .rst_n_i       (rst_n_i),
        .cfg_we_i      (cfg_we_i),
        .cfg_sel_i     (cfg_sel_i),
        .cfg_word_i    (cfg_word_i),
        .n_blocks_m1_o (n_blocks_m1),
        .subtract_dc_o (subtract_dc)
    );

    cmprs_pixel_in cmprs_pixel_in_i (
        .xclk        (xclk),
        .rst_n_i     (rst_n_i),
        .frame_en_i  (frame_en_i),
        .pre_first_i (pre_first_i),
        .pix_dv_i    (pix_dv_i),
        .pix_i       (pix_i),
        .wr          (wr_bus.src)
    );

    cmprs_block_buf cmprs_block_buf_i (
        .xclk       (xclk),
        .rst_n_i    (rst_n_i),
        .frame_en_i (frame_en_i),
        .wr         (wr_bus.dst),
        .rd         (rd_bus.buff)
    );

    cmprs_nodc_out cmprs_nodc_out_i (
        .xclk          (xclk),
        .rst_n_i       (rst_n_i),
        .frame_en_i    (frame_en_i),
        .n_blocks_m1_i (n_blocks_m1),
        .subtract_dc_i (subtract_dc),
        .rd            (rd_bus.rdr),
        .ds_o          (ds_o),
        .dv_o          (dv_o),
        .nodc_o        (nodc_o),
        .avr_o         (avr_o),
        .first_o       (first_o),
        .last_o        (last_o),
        .n000_o        (n000_o),
        .n255_o        (n255_o)
    );

endmodule

`default_nettype wire

// File: design/cmprs_nodc_out.sv
// block readout, removes dc from each pixel and marks first/last block of frame
`timescale 1ns/1ps
`default_nettype none

`include "cmprs_defs.svh"

module cmprs_nodc_out (
    input  wire                               xclk,
    input  wire                               rst_n_i,
    input  wire                               frame_en_i,    // 0 - restart frame count
    input  wire        [`CMPRS_NBLK_W-1:0]    n_blocks_m1_i,
    input  wire                               subtract_dc_i, // 0 - subtract 128
    cmprs_rd_if.rdr                           rd,
    output logic                              ds_o,          // one cycle before dv_o
    output logic                              dv_o,          // 64 cycles of data
    output logic signed [`CMPRS_NODC_W-1:0]   nodc_o,
    output logic       [`CMPRS_PIX_W-1:0]     avr_o,         // valid ds_o to ds_o
    output logic                              first_o,
    output logic                              last_o,
    output logic       [`CMPRS_CNT_W-1:0]     n000_o,
    output logic       [`CMPRS_CNT_W-1:0]     n255_o
);

    logic [`CMPRS_BLK_AW-1:0]  rcnt;      // read address counter
    logic                      rd_run;    // addresses going out
    logic [`CMPRS_NBLK_W-1:0]  blk_cnt;   // block index in frame
    logic                      blk_last;
    logic [`CMPRS_PIX_W-1:0]   sub_r;     // value subtracted from current block

    assign blk_last = (blk_cnt == n_blocks_m1_i);

    always_ff @(posedge xclk) begin
        if (!rst_n_i || !frame_en_i) begin
            rd_run  <= 1'b0;
            rcnt    <= '0;
            ds_o    <= 1'b0;
            dv_o    <= 1'b0;
            blk_cnt <= '0;
            first_o <= 1'b0;
            last_o  <= 1'b0;
        end else begin
            ds_o <= rd.blk_ready;
            dv_o <= rd_run;                  // data lags address by one cycle
            if (rd.blk_ready) begin
                rd_run  <= 1'b1;             // back to back, restarts on address 63
                rcnt    <= '0;
                first_o <= (blk_cnt == '0);
                last_o  <= blk_last;
                blk_cnt <= blk_last ? '0 : blk_cnt + 1'b1; // wrap to next frame
            end else if (rd_run) begin
                rcnt <= rcnt + 1'b1;
                if (&rcnt)
                    rd_run <= 1'b0;
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (rd.blk_ready) begin
            avr_o  <= rd.avr;
            n000_o <= rd.n000;
            n255_o <= rd.n255;
        end
        if (rd_run && (rcnt == '0))          // previous block data still leaving until now
            sub_r <= subtract_dc_i ? rd.avr : `CMPRS_PIX_W'(1 << (`CMPRS_PIX_W - 1));
    end

    assign rd.raddr = rcnt;
    assign nodc_o   = $signed({{(`CMPRS_NODC_W - `CMPRS_PIX_W){1'b0}}, rd.rdata})
                    - $signed({{(`CMPRS_NODC_W - `CMPRS_PIX_W){1'b0}}, sub_r});

endmodule

`default_nettype wire

// File: design/cmprs_block_buf.sv
// two-page block memory with per-page rounded average and 0/255 counts
`timescale 1ns/1ps
`default_nettype none

`include "cmprs_defs.svh"

module cmprs_block_buf (
    input  wire         xclk,
    input  wire         rst_n_i,
    input  wire         frame_en_i, // 0 - drop pending blk_ready
    cmprs_wr_if.dst     wr,
    cmprs_rd_if.buff    rd
);

    localparam int MEM_D = 2 << `CMPRS_BLK_AW; // two pages of 64 bytes

    logic [`CMPRS_PIX_W-1:0]  mem [0:MEM_D-1];
    logic [`CMPRS_PIX_W-1:0]  avr_pg  [0:1];   // average per page
    logic [`CMPRS_CNT_W-1:0]  n000_pg [0:1];
    logic [`CMPRS_CNT_W-1:0]  n255_pg [0:1];
    logic [`CMPRS_SUM_W-1:0]  rnd_sum;         // sum + half block, max 16352
    logic [`CMPRS_PIX_W-1:0]  rdata_r;
    logic                     done_pg;         // page of last finished block
    logic                     rd_pg;           // page being read out
    logic                     ready_r;

    assign rnd_sum = wr.blk_sum + `CMPRS_SUM_W'(1 << (`CMPRS_BLK_AW - 1));

    // pixel storage and registered read
    always_ff @(posedge xclk) begin
        if (wr.we)
            mem[{wr.wpage, wr.waddr}] <= wr.wdata;
        rdata_r <= mem[{rd_pg, rd.raddr}];   // previous page stays readable till blk_ready
    end

    // block statistics, stored into the page just finished
    always_ff @(posedge xclk) begin
        if (wr.blk_done) begin
            avr_pg[wr.wpage]  <= rnd_sum[`CMPRS_BLK_AW +: `CMPRS_PIX_W]; // divide by 64
            n000_pg[wr.wpage] <= wr.n000;
            n255_pg[wr.wpage] <= wr.n255;
        end
    end

    always_ff @(posedge xclk) begin
        if (!rst_n_i) begin
            ready_r <= 1'b0;
            done_pg <= 1'b0;
            rd_pg   <= 1'b0;
        end else if (!frame_en_i) begin
            ready_r <= 1'b0;
            done_pg <= 1'b0;
            rd_pg   <= 1'b0;
        end else begin
            ready_r <= wr.blk_done;          // one cycle after the 64th write
            if (wr.blk_done)
                done_pg <= wr.wpage;
            if (ready_r)
                rd_pg <= done_pg;            // switch readout to the finished page
        end
    end

    assign rd.blk_ready = ready_r;
    assign rd.avr       = avr_pg[done_pg];   // held until next blk_done
    assign rd.n000      = n000_pg[done_pg];
    assign rd.n255      = n255_pg[done_pg];
    assign rd.rdata     = rdata_r;

endmodule

`default_nettype wire

// File: design/cmprs_pixel_in.sv
// pixel input, writes each 64-pixel block into a page and gathers sum and 0/255 counts
`timescale 1ns/1ps
`default_nettype none

`include "cmprs_defs.svh"

module cmprs_pixel_in (
    input  wire                       xclk,
    input  wire                       rst_n_i,
    input  wire                       frame_en_i,  // 0 - clear page toggle
    input  wire                       pre_first_i, // one cycle before block
    input  wire                       pix_dv_i,    // 64 cycles per block
    input  wire [`CMPRS_PIX_W-1:0]    pix_i,
    cmprs_wr_if.src                   wr
);

    logic [`CMPRS_BLK_AW-1:0]  addr_r;   // next pixel index
    logic                      page_r;   // page being filled
    logic [`CMPRS_SUM_W-1:0]   sum_r;    // sum so far
    logic [`CMPRS_CNT_W-1:0]   n000_r;   // zero pixels so far
    logic [`CMPRS_CNT_W-1:0]   n255_r;   // 255 pixels so far
    logic [`CMPRS_SUM_W-1:0]   sum_nxt;  // including current pixel
    logic [`CMPRS_CNT_W-1:0]   n000_nxt;
    logic [`CMPRS_CNT_W-1:0]   n255_nxt;
    logic                      pix_we;
    logic                      last_pix; // 64th pixel of the block
    logic                      is_000;
    logic                      is_255;

    assign pix_we   = pix_dv_i && frame_en_i;
    assign last_pix = pix_we && (&addr_r);
    assign is_000   = (pix_i == '0);
    assign is_255   = &pix_i;
    assign sum_nxt  = sum_r + `CMPRS_SUM_W'(pix_i);
    assign n000_nxt = n000_r + `CMPRS_CNT_W'(is_000);
    assign n255_nxt = n255_r + `CMPRS_CNT_W'(is_255);

    assign wr.we       = pix_we;
    assign wr.waddr    = addr_r;
    assign wr.wpage    = page_r;
    assign wr.wdata    = pix_i;
    assign wr.blk_done = last_pix; // totals below include this pixel
    assign wr.blk_sum  = sum_nxt;
    assign wr.n000     = n000_nxt;
    assign wr.n255     = n255_nxt;

    always_ff @(posedge xclk) begin
        if (!rst_n_i) begin
            addr_r <= '0;
            page_r <= 1'b0;
        end else if (!frame_en_i) begin
            addr_r <= '0;
            page_r <= 1'b0;
        end else begin
            if (pre_first_i)
                addr_r <= '0;              // new block may start on last pixel cycle
            else if (pix_we)
                addr_r <= addr_r + 1'b1;
            if (last_pix)
                page_r <= ~page_r;         // next block goes to the other page
        end
    end

    always_ff @(posedge xclk) begin
        if (pre_first_i) begin
            sum_r  <= '0;
            n000_r <= '0;
            n255_r <= '0;
        end else if (pix_we) begin
            sum_r  <= sum_nxt;
            n000_r <= n000_nxt;
            n255_r <= n255_nxt;
        end
    end

endmodule

`default_nettype wire

// File: design/cmprs_cfg_regs.sv
// command word decoder, keeps frame length and dc mode
`timescale 1ns/1ps
`default_nettype none

`include "cmprs_defs.svh"

module cmprs_cfg_regs (
    input  wire                          xclk,
    input  wire                          rst_n_i,
    input  wire                          cfg_we_i,      // write strobe
    input  wire                          cfg_sel_i,     // 0 - frame word, 1 - mode word
    input  cmprs_cfg_pkg::cmprs_cfg_u    cfg_word_i,
    output logic [`CMPRS_NBLK_W-1:0]     n_blocks_m1_o, // blocks in frame minus 1
    output logic                         subtract_dc_o  // dc mode
);
    import cmprs_cfg_pkg::*;

    cmprs_frame_fmt_s  frame_v; // word read as frame format
    cmprs_mode_fmt_s   mode_v;  // word read as mode format
    logic              wr_frame;
    logic              wr_mode;

    assign frame_v  = cfg_word_i.frame_fmt;
    assign mode_v   = cfg_word_i.mode_fmt;
    assign wr_frame = cfg_we_i && !cfg_sel_i;
    assign wr_mode  = cfg_we_i &&  cfg_sel_i;

    always_ff @(posedge xclk) begin
        if (!rst_n_i) begin
            n_blocks_m1_o <= '0;   // one block per frame
            subtract_dc_o <= 1'b1; // real dc removal by default
        end else begin
            if (wr_frame)
                n_blocks_m1_o <= frame_v.n_blocks_m1;
            if (wr_mode)
                subtract_dc_o <= mode_v.subtract_dc;
        end
    end

endmodule

`default_nettype wire

// File: design/cmprs_blk_if.sv
// block write and block read buses between pixel input, block memory and readout
`timescale 1ns/1ps
`default_nettype none

`include "cmprs_defs.svh"

interface cmprs_wr_if;
    logic                         we;       // pixel write strobe
    logic [`CMPRS_BLK_AW-1:0]     waddr;    // pixel index inside block
    logic                         wpage;    // page being filled
    logic [`CMPRS_PIX_W-1:0]      wdata;    // pixel byte
    logic                         blk_done; // with 64th pixel
    logic [`CMPRS_SUM_W-1:0]      blk_sum;  // full block sum, valid @ blk_done
    logic [`CMPRS_CNT_W-1:0]      n000;     // zero pixels, valid @ blk_done
    logic [`CMPRS_CNT_W-1:0]      n255;     // 255 pixels, valid @ blk_done

    modport src (output we, waddr, wpage, wdata, blk_done, blk_sum, n000, n255);
    modport dst (input  we, waddr, wpage, wdata, blk_done, blk_sum, n000, n255);
endinterface

interface cmprs_rd_if;
    logic                         blk_ready; // one cycle after blk_done
    logic [`CMPRS_PIX_W-1:0]      avr;       // rounded block average, held till next blk_ready
    logic [`CMPRS_CNT_W-1:0]      n000;      // held till next blk_ready
    logic [`CMPRS_CNT_W-1:0]      n255;
    logic [`CMPRS_BLK_AW-1:0]     raddr;     // from reader
    logic [`CMPRS_PIX_W-1:0]      rdata;     // one cycle after raddr

    modport buff (output blk_ready, avr, n000, n255, rdata, input raddr);
    modport rdr  (input  blk_ready, avr, n000, n255, rdata, output raddr);
endinterface

`default_nettype wire

// File: design/cmprs_cfg_pkg.sv
// command word layout, one 32-bit word decoded as frame or mode format
`default_nettype none

package cmprs_cfg_pkg;

`include "cmprs_defs.svh"

    // frame format word, cfg_sel = 0
    typedef struct packed {
        logic [`CMPRS_NBLK_W-1:0]    n_blocks_m1; // blocks in frame minus 1
        logic [31-`CMPRS_NBLK_W:0]   reserved;    // write as 0
    } cmprs_frame_fmt_s;

    // mode format word, cfg_sel = 1
    typedef struct packed {
        logic                        subtract_dc; // 1 - subtract block average, 0 - subtract 128
        logic [30:0]                 reserved;    // write as 0
    } cmprs_mode_fmt_s;

    // same 32 bits seen through either format
    typedef union packed {
        cmprs_frame_fmt_s            frame_fmt;
        cmprs_mode_fmt_s             mode_fmt;
    } cmprs_cfg_u;

endpackage

`default_nettype wire

// File: include/cmprs_defs.svh
// block dc stage widths shared by the pixel path, block memory and readout
`ifndef CMPRS_DEFS_SVH
`define CMPRS_DEFS_SVH

// pixel byte
`define CMPRS_PIX_W   8

// address inside one 8x8 block, 64 pixels
`define CMPRS_BLK_AW  6

// sum of 64 pixels, max 16320
`define CMPRS_SUM_W   14

// counts of 0 and 255 pixels, 0..64
`define CMPRS_CNT_W   7

// signed pixel after dc removal, -255..255
`define CMPRS_NODC_W  10

// blocks per frame minus one
`define CMPRS_NBLK_W  13

`endif
